// File: Makefile
VERILATOR ?= verilator
TOP       := tb_int_exec_cluster
FILELIST  := compile.f
VFLAGS    := --timing
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: compile.f
+incdir+verification
src/ncpu_cfg_pkg.sv
src/ncpu_uop_pkg.sv
src/mrf_nwnr_r.sv
src/issue_fifo.sv
src/cfg_regs.sv
src/opr_fetch.sv
src/alu_exec.sv
src/int_exec_cluster.sv
verification/tb_int_exec_cluster.sv

// File: src/alu_exec.sv
`timescale 1ns/10ps
module alu_exec #(
   parameter int DW = 32
) (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic                    op_valid,
   input  ncpu_uop_pkg::alu_op_t   op_alu,
   input  ncpu_cfg_pkg::reg_addr_t op_rd,
   input  logic [DW-1:0]           op_a,
   input  logic [DW-1:0]           op_b,
   output logic                    wb_we,       // Also res_valid at the top
   output ncpu_cfg_pkg::reg_addr_t wb_waddr,
   output logic [DW-1:0]           wb_wdata
);

   logic [DW-1:0] result;                    // Combinational ALU output

   always_comb begin
      case (op_alu)
         ncpu_uop_pkg::ALU_ADD: result = op_a + op_b;
         ncpu_uop_pkg::ALU_SUB: result = op_a - op_b;
         ncpu_uop_pkg::ALU_AND: result = op_a & op_b;
         ncpu_uop_pkg::ALU_OR:  result = op_a | op_b;
         ncpu_uop_pkg::ALU_XOR: result = op_a ^ op_b;
         ncpu_uop_pkg::ALU_SLL: result = op_a << op_b[4:0];   // Low 5 bits only
         default:               result = '0;                  // Unused encodings
      endcase
   end

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         wb_we <= 1'b0;
      end else begin
         wb_we <= op_valid;                  // Single-cycle pulse per op
      end
   end

   always_ff @(posedge CLK) begin
      if (op_valid) begin
         wb_waddr <= op_rd;
         wb_wdata <= result;
      end
   end

endmodule

// File: src/cfg_regs.sv
`timescale 1ns/10ps
module cfg_regs (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic                    cfg_we,
   input  ncpu_uop_pkg::cfg_addr_t cfg_addr,
   input  ncpu_cfg_pkg::data_t     cfg_wdata,
   output ncpu_cfg_pkg::data_t     cfg_rdata,    // Combinational readback
   output logic                    bypass_en,
   output logic                    issue_halt
);

   logic bypass_q;                           // CTRL bit 0
   logic halt_q;                             // CTRL bit 1
   logic ctrl_wr;

   assign ctrl_wr = cfg_we && (cfg_addr == ncpu_uop_pkg::CFG_CTRL);

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         bypass_q <= 1'b1;                   // Bypass on out of reset
         halt_q   <= 1'b0;
      end else if (ctrl_wr) begin
         bypass_q <= cfg_wdata[ncpu_uop_pkg::CTRL_BYPASS_BIT];
         halt_q   <= cfg_wdata[ncpu_uop_pkg::CTRL_HALT_BIT];
      end
   end

   // Unmapped addresses and unused CTRL bits read zero
   always_comb begin
      cfg_rdata = '0;
      if (cfg_addr == ncpu_uop_pkg::CFG_CTRL) begin
         cfg_rdata[ncpu_uop_pkg::CTRL_BYPASS_BIT] = bypass_q;
         cfg_rdata[ncpu_uop_pkg::CTRL_HALT_BIT]   = halt_q;
      end
   end

   assign bypass_en  = bypass_q;
   assign issue_halt = halt_q;

endmodule

// File: src/int_exec_cluster.sv
`timescale 1ns/10ps
module int_exec_cluster #(
   parameter int DW     = ncpu_cfg_pkg::DATA_W,
   parameter int AW     = ncpu_cfg_pkg::RADDR_W,
   parameter int QDEPTH = ncpu_cfg_pkg::QUEUE_DEPTH,
   parameter logic [DW*(1<<AW)-1:0] RF_RST_VECTOR = {(1 << AW){DW'(32'hA5C3_0F1E)}}
) (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic                    uop_valid,    // Issue port, credit gated
   input  ncpu_uop_pkg::alu_op_t   uop_op,
   input  ncpu_uop_pkg::src_sel_t  uop_sel,
   input  logic [AW-1:0]           uop_rd,
   input  logic [AW-1:0]           uop_rs1,
   input  logic [AW-1:0]           uop_rs2,
   input  ncpu_uop_pkg::imm_t      uop_imm,
   output logic                    uop_credit,   // One per dequeued op
   output logic                    res_valid,
   output logic [AW-1:0]           res_rd,
   output logic [DW-1:0]           res_data,
   input  logic                    ld_we,        // Load return, RF port 1
   input  logic [AW-1:0]           ld_waddr,
   input  logic [DW-1:0]           ld_wdata,
   input  logic                    cfg_we,
   input  ncpu_uop_pkg::cfg_addr_t cfg_addr,
   input  ncpu_cfg_pkg::data_t     cfg_wdata,
   output ncpu_cfg_pkg::data_t     cfg_rdata
);

   logic [ncpu_uop_pkg::UOP_W-1:0] push_uop;
   logic [ncpu_uop_pkg::UOP_W-1:0] q_uop;
   logic                           q_valid;
   logic                           q_pop;
   logic                           bypass_en;
   logic                           issue_halt;
   logic [1:0]                     rf_re;
   logic [2*AW-1:0]                rf_raddr;
   logic [2*DW-1:0]                rf_rdata;
   logic [1:0]                     rf_we;        // Port 1 load, port 0 ALU
   logic [2*AW-1:0]                rf_waddr;
   logic [2*DW-1:0]                rf_wdata;
   logic                           op_valid;
   ncpu_uop_pkg::alu_op_t          op_alu;
   logic [AW-1:0]                  op_rd;
   logic [DW-1:0]                  op_a;
   logic [DW-1:0]                  op_b;
   logic                           wb_we;
   logic [AW-1:0]                  wb_waddr;
   logic [DW-1:0]                  wb_wdata;

   assign push_uop = {uop_op, uop_sel, uop_rd, uop_rs1, uop_rs2, uop_imm};

   // Load port sits above writeback so it wins same-rd clashes
   assign rf_we    = {ld_we, wb_we};
   assign rf_waddr = {ld_waddr, wb_waddr};
   assign rf_wdata = {ld_wdata, wb_wdata};

   assign res_valid = wb_we;                 // Writeback doubles as result port
   assign res_rd    = wb_waddr;
   assign res_data  = wb_wdata;

   issue_fifo #(.QDEPTH(QDEPTH), .W(ncpu_uop_pkg::UOP_W)) u_issue_fifo (
      .CLK(CLK), .RST(RST),
      .push(uop_valid), .push_data(push_uop),
      .pop(q_pop), .q_valid(q_valid), .q_data(q_uop),
      .credit(uop_credit)
   );

   cfg_regs u_cfg_regs (
      .CLK(CLK), .RST(RST),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
      .bypass_en(bypass_en), .issue_halt(issue_halt)
   );

   opr_fetch #(.DW(DW), .AW(AW)) u_opr_fetch (
      .CLK(CLK), .RST(RST),
      .q_valid(q_valid), .q_data(q_uop), .q_pop(q_pop),
      .bypass_en(bypass_en), .issue_halt(issue_halt),
      .re(rf_re), .raddr(rf_raddr), .rdata(rf_rdata),
      .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
      .op_valid(op_valid), .op_alu(op_alu), .op_rd(op_rd), .op_a(op_a), .op_b(op_b)
   );

   alu_exec #(.DW(DW)) u_alu_exec (
      .CLK(CLK), .RST(RST),
      .op_valid(op_valid), .op_alu(op_alu), .op_rd(op_rd), .op_a(op_a), .op_b(op_b),
      .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
   );

   mrf_nwnr_r #(
      .DW(DW), .AW(AW), .NUM_READ(2), .NUM_WRITE(2), .RST_VECTOR(RF_RST_VECTOR)
   ) u_mrf (
      .CLK(CLK), .RST(RST),
      .RE(rf_re), .RADDR(rf_raddr), .RDATA(rf_rdata),
      .WE(rf_we), .WADDR(rf_waddr), .WDATA(rf_wdata)
   );

endmodule

// File: src/issue_fifo.sv
`timescale 1ns/10ps
module issue_fifo #(
   parameter int QDEPTH = 4,
   parameter int W      = 28
) (
   input  logic         CLK,
   input  logic         RST,
   input  logic         push,                // Issuer write, must hold a credit
   input  logic [W-1:0] push_data,
   input  logic         pop,
   output logic         q_valid,             // Head entry present
   output logic [W-1:0] q_data,              // Head entry
   output logic         credit               // One pulse per entry that leaves
);

   localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
   localparam int CW = $clog2(QDEPTH + 1);

   logic [W-1:0]  mem [QDEPTH];              // Entry storage
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;                     // Occupancy
   logic          full;
   logic          do_push;
   logic          do_pop;

   // Wrap at QDEPTH, depth need not be a power of two
   function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
      if (p == PW'(QDEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign full    = (count == CW'(QDEPTH));
   assign q_valid = (count != '0);
   assign q_data  = mem[rd_ptr];
   assign do_push = push & ~full;            // Write without credit is dropped when full
   assign do_pop  = pop & q_valid;
   assign credit  = do_pop;                  // Same cycle as the pop

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;           // Poppable from next cycle
      end
   end

endmodule

// File: src/mrf_nwnr_r.sv
`timescale 1ns/10ps
module mrf_nwnr_r #(
   parameter int DW        = 32,
   parameter int AW        = 4,
   parameter int NUM_READ  = 2,
   parameter int NUM_WRITE = 2,
   parameter logic [DW*(1<<AW)-1:0] RST_VECTOR = '0    // Register j at [j*DW +: DW]
) (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic [NUM_READ-1:0]     RE,
   input  logic [NUM_READ*AW-1:0]  RADDR,
   output logic [NUM_READ*DW-1:0]  RDATA,
   input  logic [NUM_WRITE-1:0]    WE,
   input  logic [NUM_WRITE*AW-1:0] WADDR,
   input  logic [NUM_WRITE*DW-1:0] WDATA
);

   localparam int NREGS = 1 << AW;

   logic [DW-1:0] regs [NREGS];              // Architectural state
   logic [DW-1:0] rd_q [NUM_READ];           // Registered read data

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int j = 0; j < NREGS; j++) begin
            regs[j] <= RST_VECTOR[j*DW +: DW];   // Load reset vector
         end
      end else begin
         // Later ports overwrite earlier ones, so highest port wins a clash
         for (int j = 0; j < NUM_WRITE; j++) begin
            if (WE[j]) begin
               regs[WADDR[j*AW +: AW]] <= WDATA[j*DW +: DW];
            end
         end
      end
   end

   genvar i;
   generate
      for (i = 0; i < NUM_READ; i++) begin : g_rd
         always_ff @(posedge CLK) begin
            if (RE[i]) begin
               rd_q[i] <= regs[RADDR[i*AW +: AW]];   // Sees state before this edge's writes
            end
         end

         assign RDATA[i*DW +: DW] = rd_q[i];          // Valid the cycle after RE
      end
   endgenerate

endmodule

// File: src/ncpu_cfg_pkg.sv
package ncpu_cfg_pkg;

   // Default core sizing, fed into the cluster top parameters
   localparam int DATA_W      = 32;          // Register and result width
   localparam int RADDR_W     = 4;           // 16 architectural registers
   localparam int QUEUE_DEPTH = 4;           // Issue queue entries, also initial credits

   // Register word as seen by config port and result path
   typedef logic [DATA_W-1:0]  data_t;

   // Register index
   typedef logic [RADDR_W-1:0] reg_addr_t;

endpackage

// File: src/ncpu_uop_pkg.sv
package ncpu_uop_pkg;

   typedef logic [2:0]  alu_op_t;            // ALU function select
   typedef logic        src_sel_t;           // Operand B source
   typedef logic [11:0] imm_t;               // Zero-extended at use
   typedef logic [1:0]  cfg_addr_t;          // Config register index

   localparam alu_op_t ALU_ADD = 3'd0;
   localparam alu_op_t ALU_SUB = 3'd1;
   localparam alu_op_t ALU_AND = 3'd2;
   localparam alu_op_t ALU_OR  = 3'd3;
   localparam alu_op_t ALU_XOR = 3'd4;
   localparam alu_op_t ALU_SLL = 3'd5;       // Shift by B[4:0]

   localparam src_sel_t SRC_REG = 1'b0;      // B from rs2
   localparam src_sel_t SRC_IMM = 1'b1;      // B from immediate

   // Config register map
   localparam cfg_addr_t CFG_CTRL        = 2'd0;
   localparam int        CTRL_BYPASS_BIT = 0;     // Write bypass enable
   localparam int        CTRL_HALT_BIT   = 1;     // Stop popping the issue queue

   // Queue entry {op, sel, rd, rs1, rs2, imm}, imm in the low bits
   localparam int UOP_W = $bits(alu_op_t) + $bits(src_sel_t)
                        + 3 * ncpu_cfg_pkg::RADDR_W + $bits(imm_t);

endpackage

// File: src/opr_fetch.sv
`timescale 1ns/10ps
module opr_fetch #(
   parameter int DW = 32,
   parameter int AW = 4
) (
   input  logic                          CLK,
   input  logic                          RST,
   input  logic                          q_valid,
   input  logic [ncpu_uop_pkg::UOP_W-1:0] q_data,
   output logic                          q_pop,
   input  logic                          bypass_en,
   input  logic                          issue_halt,
   output logic [1:0]                    re,        // Port 0 rs1, port 1 rs2
   output logic [2*AW-1:0]               raddr,
   input  logic [2*DW-1:0]               rdata,
   input  logic [1:0]                    we,        // RF write ports, snooped for bypass
   input  logic [2*AW-1:0]               waddr,
   input  logic [2*DW-1:0]               wdata,
   output logic                          op_valid,
   output ncpu_uop_pkg::alu_op_t         op_alu,
   output logic [AW-1:0]                 op_rd,
   output logic [DW-1:0]                 op_a,
   output logic [DW-1:0]                 op_b
);

   localparam int NP      = 2;               // Read and write port count
   localparam int IW      = $bits(ncpu_uop_pkg::imm_t);
   localparam int RS1_LSB = IW + AW;
   localparam int RD_LSB  = IW + 2 * AW;
   localparam int SEL_LSB = IW + 3 * AW;
   localparam int OP_LSB  = SEL_LSB + 1;

   logic [AW-1:0]          rs1;
   logic [AW-1:0]          rs2;
   logic                   hit_a, hit_b;     // Same-cycle write to a source
   logic [DW-1:0]          fwd_a, fwd_b;
   logic                   byp_a_q, byp_b_q; // Use forwarded data next cycle
   logic [DW-1:0]          fwd_a_q, fwd_b_q;
   ncpu_uop_pkg::src_sel_t sel_q;
   ncpu_uop_pkg::imm_t     imm_q;
   logic [DW-1:0]          b_reg;

   assign rs1   = q_data[RS1_LSB +: AW];
   assign rs2   = q_data[IW +: AW];
   assign q_pop = q_valid & ~issue_halt;     // Halt backs up the queue
   assign re    = {NP{q_pop}};
   assign raddr = {rs2, rs1};

   // Ascending scan so the highest hitting port wins, as in the RF
   always_comb begin
      hit_a = 1'b0;
      hit_b = 1'b0;
      fwd_a = '0;
      fwd_b = '0;
      for (int j = 0; j < NP; j++) begin
         if (we[j] && (waddr[j*AW +: AW] == rs1)) begin
            hit_a = 1'b1;
            fwd_a = wdata[j*DW +: DW];
         end
         if (we[j] && (waddr[j*AW +: AW] == rs2)) begin
            hit_b = 1'b1;
            fwd_b = wdata[j*DW +: DW];
         end
      end
   end

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         op_valid <= 1'b0;
         byp_a_q  <= 1'b0;
         byp_b_q  <= 1'b0;
      end else begin
         op_valid <= q_pop;                  // One cycle behind the read
         byp_a_q  <= q_pop & bypass_en & hit_a;
         byp_b_q  <= q_pop & bypass_en & hit_b;
      end
   end

   always_ff @(posedge CLK) begin
      if (q_pop) begin
         op_alu  <= q_data[OP_LSB +: $bits(ncpu_uop_pkg::alu_op_t)];
         sel_q   <= q_data[SEL_LSB];
         op_rd   <= q_data[RD_LSB +: AW];
         imm_q   <= q_data[IW-1:0];
         fwd_a_q <= fwd_a;
         fwd_b_q <= fwd_b;
      end
   end

   assign op_a  = byp_a_q ? fwd_a_q : rdata[0 +: DW];
   assign b_reg = byp_b_q ? fwd_b_q : rdata[DW +: DW];
   assign op_b  = (sel_q == ncpu_uop_pkg::SRC_REG) ? b_reg : DW'(imm_q);  // Imm zero-extended

endmodule

// File: verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] m_regs [16];                    // Architectural register copy
logic [27:0] m_q [$];                        // Accepted ops {op, sel, rd, rs1, rs2, imm}
logic        m_bypass;
logic        m_halt;
logic        m_s1_valid;                     // Operand stage
logic [2:0]  m_s1_op;
logic [3:0]  m_s1_rd;
logic [31:0] m_s1_a;
logic [31:0] m_s1_b;
logic        m_wb_valid;                     // Writeback stage, drives result port
logic [3:0]  m_wb_rd;
logic [31:0] m_wb_data;
logic [3:0]  exp_rd [$];                     // Expected results in order
logic [31:0] exp_data [$];
int          m_pushed;

function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
   case (op)
      ncpu_uop_pkg::ALU_ADD: return a + b;
      ncpu_uop_pkg::ALU_SUB: return a - b;
      ncpu_uop_pkg::ALU_AND: return a & b;
      ncpu_uop_pkg::ALU_OR:  return a | b;
      ncpu_uop_pkg::ALU_XOR: return a ^ b;
      ncpu_uop_pkg::ALU_SLL: return a << b[4:0];
      default:               return 32'd0;
   endcase
endfunction

// Source value seen by a read popped this cycle
function automatic logic [31:0] src_value(input logic [3:0] r, input logic lwe,
                                          input logic [3:0] lad, input logic [31:0] ldat);
   logic [31:0] v;
   v = m_regs[r];
   if (m_bypass) begin
      if (m_wb_valid && m_wb_rd == r) v = m_wb_data;   // Port 0
      if (lwe && lad == r) v = ldat;                   // Port 1 wins
   end
   return v;
endfunction

task automatic model_reset();
   for (int j = 0; j < 16; j++) begin
      m_regs[j] = RST_VEC[j*32 +: 32];
   end
   m_q.delete();
   exp_rd.delete();
   exp_data.delete();
   m_bypass   = 1'b1;
   m_halt     = 1'b0;
   m_s1_valid = 1'b0;
   m_wb_valid = 1'b0;
   m_pushed   = 0;
endtask

// Advances the model across the coming rising edge
task automatic model_step(input logic vld, input logic [27:0] uop, input logic lwe,
                          input logic [3:0] lad, input logic [31:0] ldat, input logic cwe,
                          input logic [1:0] cad, input logic [31:0] cdat);
   logic        do_pop;
   logic [27:0] head;
   logic [31:0] a;
   logic [31:0] b;
   do_pop = (m_q.size() != 0) && !m_halt;
   head   = do_pop ? m_q[0] : 28'd0;
   a      = src_value(head[19:16], lwe, lad, ldat);
   b      = (head[24] == ncpu_uop_pkg::SRC_IMM) ? {20'd0, head[11:0]}
          : src_value(head[15:12], lwe, lad, ldat);
   if (m_wb_valid) m_regs[m_wb_rd] = m_wb_data;
   if (lwe) m_regs[lad] = ldat;              // Load after ALU, so it wins
   if (m_s1_valid) begin
      exp_rd.push_back(m_s1_rd);
      exp_data.push_back(alu_ref(m_s1_op, m_s1_a, m_s1_b));
   end
   m_wb_valid = m_s1_valid;
   m_wb_rd    = m_s1_rd;
   m_wb_data  = alu_ref(m_s1_op, m_s1_a, m_s1_b);
   m_s1_valid = do_pop;
   m_s1_op    = head[27:25];
   m_s1_rd    = head[23:20];
   m_s1_a     = a;
   m_s1_b     = b;
   if (vld && m_q.size() < QDEPTH) begin     // Full queue drops the write
      m_q.push_back(uop);
      m_pushed++;
   end
   if (do_pop) void'(m_q.pop_front());
   if (cwe && cad == ncpu_uop_pkg::CFG_CTRL) begin
      m_bypass = cdat[ncpu_uop_pkg::CTRL_BYPASS_BIT];
      m_halt   = cdat[ncpu_uop_pkg::CTRL_HALT_BIT];
   end
endtask

`endif

// File: verification/tb_int_exec_cluster.sv
`timescale 1ns/10ps
module tb_int_exec_cluster;

   localparam int QDEPTH     = 4;
   localparam int WAIT_LIMIT = 200;          // Cycles per wait loop

   function automatic logic [511:0] make_rst_vec();
      logic [511:0] v;
      for (int j = 0; j < 16; j++) begin
         v[j*32 +: 32] = 32'h5A00_0000 + 32'(j) * 32'h0102_0305;   // Distinct word per reg
      end
      return v;
   endfunction

   localparam logic [511:0] RST_VEC = make_rst_vec();

   logic                    CLK;
   logic                    RST;
   logic                    uop_valid;
   ncpu_uop_pkg::alu_op_t   uop_op;
   ncpu_uop_pkg::src_sel_t  uop_sel;
   logic [3:0]              uop_rd;
   logic [3:0]              uop_rs1;
   logic [3:0]              uop_rs2;
   ncpu_uop_pkg::imm_t      uop_imm;
   logic                    uop_credit;
   logic                    res_valid;
   logic [3:0]              res_rd;
   logic [31:0]             res_data;
   logic                    ld_we;
   logic [3:0]              ld_waddr;
   logic [31:0]             ld_wdata;
   logic                    cfg_we;
   ncpu_uop_pkg::cfg_addr_t cfg_addr;
   logic [31:0]             cfg_wdata;
   logic [31:0]             cfg_rdata;

   int          err_value;
   int          err_other;
   int          credits;                     // Issuer-side credit count
   int          ret_credits;
   logic        in_halt;                     // No credit or result allowed
   string       test_name;
   int unsigned rng_state;

   `include "tb_ref_model.svh"

   int_exec_cluster #(.DW(32), .AW(4), .QDEPTH(QDEPTH), .RF_RST_VECTOR(RST_VEC))
      u_int_exec_cluster (
      .CLK(CLK), .RST(RST),
      .uop_valid(uop_valid), .uop_op(uop_op), .uop_sel(uop_sel), .uop_rd(uop_rd),
      .uop_rs1(uop_rs1), .uop_rs2(uop_rs2), .uop_imm(uop_imm), .uop_credit(uop_credit),
      .res_valid(res_valid), .res_rd(res_rd), .res_data(res_data),
      .ld_we(ld_we), .ld_waddr(ld_waddr), .ld_wdata(ld_wdata),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
   );

   always #50 CLK = ~CLK;                    // 100 ns period

   function automatic int unsigned next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state >> 8;                 // Drop weak low bits
   endfunction

   // Checks and model step sampled mid-cycle where outputs are settled
   always @(negedge CLK) begin
      logic [3:0]  e_rd;
      logic [31:0] e_dat;
      logic [31:0] e_cfg;
      logic        e_credit;
      if (!RST) begin
         model_reset();
         credits     = QDEPTH;
         ret_credits = 0;
      end else begin
         e_credit = (m_q.size() != 0) && !m_halt;   // Pop whenever queued and not halted
         assert (uop_credit == e_credit) else begin
            err_value++;
            $display("[FAIL] %s: uop_credit expected %0b, actual %0b", test_name,
                     e_credit, uop_credit);
         end
         assert (res_valid == m_wb_valid) else begin
            err_value++;
            $display("[FAIL] %s: res_valid expected %0b, actual %0b", test_name,
                     m_wb_valid, res_valid);
         end
         if (res_valid && exp_rd.size() != 0) begin
            e_rd  = exp_rd.pop_front();
            e_dat = exp_data.pop_front();
            assert (res_rd == e_rd && res_data == e_dat) else begin
               err_value++;
               $display("[FAIL] %s: expected rd=%0d data=%h, actual rd=%0d data=%h",
                        test_name, e_rd, e_dat, res_rd, res_data);
            end
         end
         if (in_halt) begin
            assert (!uop_credit && !res_valid) else begin
               err_other++;
               $display("%s: a credit or result appeared while issue was halted", test_name);
            end
         end
         e_cfg = (cfg_addr == ncpu_uop_pkg::CFG_CTRL) ? {30'd0, m_halt, m_bypass} : 32'd0;
         assert (cfg_rdata == e_cfg) else begin
            err_value++;
            $display("[FAIL] %s: cfg_rdata expected %h, actual %h", test_name, e_cfg,
                     cfg_rdata);
         end
         if (uop_valid) credits--;
         if (uop_credit) begin
            credits++;
            ret_credits++;
         end
         assert (credits >= 0 && credits <= QDEPTH) else begin
            err_other++;
            $display("%s: issuer credit count left the range 0 to %0d", test_name, QDEPTH);
         end
         model_step(uop_valid, {uop_op, uop_sel, uop_rd, uop_rs1, uop_rs2, uop_imm},
                    ld_we, ld_waddr, ld_wdata, cfg_we, cfg_addr, cfg_wdata);
      end
   end

   task automatic idle_cycle();
      @(posedge CLK);
      uop_valid <= 1'b0;
      ld_we     <= 1'b0;
      cfg_we    <= 1'b0;
   endtask

   task automatic drive_random_uop();
      uop_valid <= 1'b1;
      uop_op    <= 3'(next_rand() % 6);
      uop_sel   <= 1'(next_rand() % 2);
      uop_rd    <= 4'(next_rand());
      uop_rs1   <= 4'(next_rand());
      uop_rs2   <= 4'(next_rand());
      uop_imm   <= 12'(next_rand());
   endtask

   // Waits for a credit then presents one op for a cycle
   task automatic send_uop(input logic [2:0] op, input logic sel, input logic [3:0] rd,
                           input logic [3:0] rs1, input logic [3:0] rs2, input logic [11:0] imm);
      int t;
      t = 0;
      @(posedge CLK);
      while (credits == 0 && t < WAIT_LIMIT) begin
         uop_valid <= 1'b0;
         @(posedge CLK);
         t++;
      end
      if (credits == 0) begin
         err_other++;
         $display("%s: timed out waiting for an issue credit", test_name);
         uop_valid <= 1'b0;
      end else begin
         uop_valid <= 1'b1;
         uop_op    <= op;
         uop_sel   <= sel;
         uop_rd    <= rd;
         uop_rs1   <= rs1;
         uop_rs2   <= rs2;
         uop_imm   <= imm;
      end
   endtask

   task automatic drain();
      int t;
      t = 0;
      idle_cycle();
      while ((m_q.size() != 0 || m_s1_valid || m_wb_valid) && t < WAIT_LIMIT) begin
         idle_cycle();
         t++;
      end
      if (m_q.size() != 0 || m_s1_valid || m_wb_valid) begin
         err_other++;
         $display("%s: timed out waiting for the pipeline to drain", test_name);
      end
   endtask

   task automatic cfg_write(input logic [31:0] d);
      @(posedge CLK);
      uop_valid <= 1'b0;
      cfg_we    <= 1'b1;
      cfg_addr  <= ncpu_uop_pkg::CFG_CTRL;
      cfg_wdata <= d;
      idle_cycle();
   endtask

   // OR-immediate-0 into itself returns value and issue-to-result latency
   task automatic read_reg(input logic [3:0] r, output logic [31:0] d, output int lat);
      send_uop(ncpu_uop_pkg::ALU_OR, ncpu_uop_pkg::SRC_IMM, r, r, 4'd0, 12'd0);
      lat = 0;
      @(negedge CLK);
      while (!res_valid && lat < WAIT_LIMIT) begin
         @(posedge CLK);
         uop_valid <= 1'b0;
         @(negedge CLK);
         lat++;
      end
      if (!res_valid) begin
         err_other++;
         $display("%s: timed out waiting for res_valid", test_name);
      end
      d = res_data;
      idle_cycle();
   endtask

   task automatic random_step();
      @(posedge CLK);
      uop_valid <= 1'b0;
      ld_we     <= 1'b0;
      cfg_we    <= 1'b0;
      if (credits > 0 && next_rand() % 4 != 0) drive_random_uop();
      if (next_rand() % 4 == 0) begin
         ld_we    <= 1'b1;
         ld_waddr <= 4'(next_rand());
         ld_wdata <= next_rand() ^ (next_rand() << 16);
      end
      cfg_addr <= 2'(next_rand());           // Random readback address
      if (next_rand() % 40 == 0) begin
         cfg_we    <= 1'b1;
         cfg_wdata <= 32'(next_rand() % 2);  // Bypass toggle with halt off
      end
   endtask

   // Producer then dependent plus a load racing a dependent read
   task automatic bypass_pair();
      send_uop(ncpu_uop_pkg::ALU_ADD, ncpu_uop_pkg::SRC_IMM, 4'd9, 4'd9, 4'd0, 12'h111);
      idle_cycle();
      send_uop(ncpu_uop_pkg::ALU_ADD, ncpu_uop_pkg::SRC_REG, 4'd10, 4'd9, 4'd9, 12'd0);
      drain();
      send_uop(ncpu_uop_pkg::ALU_XOR, ncpu_uop_pkg::SRC_REG, 4'd11, 4'd12, 4'd0, 12'd0);
      @(posedge CLK);
      uop_valid <= 1'b0;
      ld_we     <= 1'b1;                     // Same cycle as the dependent read
      ld_waddr  <= 4'd12;
      ld_wdata  <= next_rand();
      drain();
   endtask

   initial begin
      logic [31:0] d;
      int          lat;
      int          ret_before;
      RST       = 1'b0;
      CLK       = 1'b0;
      uop_valid = 1'b0;
      uop_op    = '0;
      uop_sel   = '0;
      uop_rd    = '0;
      uop_rs1   = '0;
      uop_rs2   = '0;
      uop_imm   = '0;
      ld_we     = 1'b0;
      ld_waddr  = '0;
      ld_wdata  = '0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      err_value = 0;
      err_other = 0;
      in_halt   = 1'b0;
      rng_state = 97965;
      test_name = "reset";
      repeat (5) @(posedge CLK);
      RST <= 1'b1;
      idle_cycle();

      test_name = "reset_vector";
      for (int r = 0; r < 16; r++) begin
         read_reg(4'(r), d, lat);
         assert (d == RST_VEC[r*32 +: 32]) else begin
            err_value++;
            $display("[FAIL] %s: r%0d expected %h, actual %h", test_name, r,
                     RST_VEC[r*32 +: 32], d);
         end
         assert (lat == 3) else begin
            err_value++;
            $display("[FAIL] %s latency: expected 3, actual %0d", test_name, lat);
         end
      end

      test_name = "random_alu";
      repeat (400) random_step();
      drain();
      cfg_write(32'h1);

      test_name = "write_priority";
      send_uop(ncpu_uop_pkg::ALU_ADD, ncpu_uop_pkg::SRC_IMM, 4'd7, 4'd3, 4'd0, 12'h055);
      idle_cycle();
      idle_cycle();
      @(posedge CLK);
      ld_we    <= 1'b1;                      // Lands with the ALU writeback
      ld_waddr <= 4'd7;
      ld_wdata <= 32'hC0DE_7777;
      @(negedge CLK);
      assert (res_valid && res_rd == 4'd7) else begin
         err_other++;
         $display("%s: the ALU writeback did not coincide with the load write", test_name);
      end
      drain();
      read_reg(4'd7, d, lat);
      assert (d == 32'hC0DE_7777) else begin
         err_value++;
         $display("[FAIL] %s: expected %h, actual %h", test_name, 32'hC0DE_7777, d);
      end

      test_name = "bypass_on";
      bypass_pair();
      cfg_write(32'h0);
      test_name = "bypass_off";
      bypass_pair();
      cfg_write(32'h1);

      test_name = "halt_credit";
      cfg_write(32'h3);
      repeat (3) idle_cycle();
      in_halt = 1'b1;
      repeat (8 + next_rand() % 8) begin
         @(posedge CLK);
         uop_valid <= 1'b0;
         if (credits > 0) drive_random_uop();
      end
      idle_cycle();
      in_halt    = 1'b0;
      ret_before = ret_credits;
      cfg_write(32'h1);
      drain();
      assert (ret_credits - ret_before == QDEPTH) else begin
         err_value++;
         $display("[FAIL] %s: expected %0d credits after release, actual %0d", test_name,
                  QDEPTH, ret_credits - ret_before);
      end
      assert (credits == QDEPTH) else begin
         err_value++;
         $display("[FAIL] %s: expected %0d credits, actual %0d", test_name, QDEPTH, credits);
      end

      test_name = "cfg_readback";
      for (int v = 0; v < 4; v++) begin
         cfg_write(32'(v));
         for (int a = 0; a < 4; a++) begin
            @(posedge CLK);
            cfg_addr <= 2'(a);
            @(negedge CLK);
            assert (cfg_rdata == ((a == 0) ? 32'(v) : 32'd0)) else begin
               err_value++;
               $display("[FAIL] %s: addr %0d expected %h, actual %h", test_name, a,
                        (a == 0) ? 32'(v) : 32'd0, cfg_rdata);
            end
         end
      end
      cfg_write(32'h1);
      drain();

      test_name = "credit_total";
      assert (ret_credits == m_pushed) else begin
         err_value++;
         $display("[FAIL] %s: expected %0d, actual %0d", test_name, m_pushed, ret_credits);
      end

      $display("Errors: value=%0d other=%0d", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
